//--- hw/dbg_apb_regs.sv
`timescale 1ns/100ps
`default_nettype none
`include "msg_settings.svh"

module dbg_apb_regs (
	input  logic snk_clk,
	input  logic reset,
	input  dbg_regs_pkg::apb_req_t apb_req,
	output dbg_regs_pkg::apb_rsp_t apb_rsp,
	output dbg_regs_pkg::ctrl_t ctrl,
	output logic clear,
	input  dbg_regs_pkg::err_flags_t flags,
	input  logic [15:0] rx_count,
	input  msg_types_pkg::msg_t last_msg
);
	import dbg_regs_pkg::*;

	reg_idx_e idx;
	logic access;
	logic wr_en;

	always_comb begin
		case (apb_req.paddr)
			`REG_CTRL_OFS: idx = CTRL;
			`REG_STATUS_OFS: idx = STATUS;
			`REG_COUNT_OFS: idx = COUNT;
			`REG_LAST_OFS: idx = LAST;
			default: idx = NONE;
		endcase
	end

	assign access = apb_req.psel && apb_req.penable;
	assign wr_en = access && apb_req.pwrite;

	always_ff @(posedge snk_clk) begin
		if (reset) begin
			ctrl <= '0;
			clear <= 1'b0;
		end else begin
			// Inject bits live for one cycle
			ctrl.inject_red <= 1'b0;
			ctrl.inject_seq <= 1'b0;
			clear <= wr_en && (idx == STATUS) && apb_req.pwdata[3];
			if (wr_en && idx == CTRL) begin
				ctrl.enable <= apb_req.pwdata[0];
				ctrl.inject_red <= apb_req.pwdata[1];
				ctrl.inject_seq <= apb_req.pwdata[2];
			end
		end
	end

	// Zero-wait slave
	always_comb begin
		apb_rsp.pready = 1'b1;
		apb_rsp.pslverr = access && (idx == NONE);
		apb_rsp.prdata = '0;
		case (idx)
			CTRL: apb_rsp.prdata[$bits(ctrl_t)-1:0] = ctrl;
			STATUS: apb_rsp.prdata[$bits(err_flags_t)-1:0] = flags;
			COUNT: apb_rsp.prdata[15:0] = rx_count;
			LAST: apb_rsp.prdata[$bits(last_msg)-1:0] = last_msg;
			default: apb_rsp.prdata = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- hw/dbg_regs_pkg.sv
`default_nettype none
`include "msg_settings.svh"

package dbg_regs_pkg;

	typedef logic [`APB_ADDR_W-1:0] apb_addr_t;
	typedef logic [`APB_DATA_W-1:0] apb_data_t;

	typedef struct packed {
		logic psel;
		logic penable;
		logic pwrite;
		apb_addr_t paddr;
		apb_data_t pwdata;
	} apb_req_t;

	typedef struct packed {
		apb_data_t prdata;
		logic pready;
		logic pslverr;
	} apb_rsp_t;

	typedef enum logic [2:0] {CTRL, STATUS, COUNT, LAST, NONE} reg_idx_e;

	// enable is bit 0
	typedef struct packed {
		logic inject_seq;
		logic inject_red;
		logic enable;
	} ctrl_t;

	// bad_src is bit 0, any is bit 3
	typedef struct packed {
		logic any;
		logic bad_seq;
		logic bad_red;
		logic bad_src;
	} err_flags_t;

endpackage

`default_nettype wire

//--- hw/link_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

module link_arbiter (
	input  logic snk_clk,
	input  logic reset,
	input  msg_types_pkg::msg_t src_msg [2],
	input  logic src_valid [2],
	output logic src_take [2],
	output msg_types_pkg::msg_t link_msg,
	output logic link_req,
	input  logic link_ack
);
	import msg_types_pkg::*;

	typedef enum logic [1:0] {IDLE, REQ, WAIT_LOW} state_e;

	state_e state;
	logic ptr;
	logic gnt;
	logic any_valid;

	assign any_valid = src_valid[0] || src_valid[1];
	// Pointer side first, else the other one
	assign gnt = src_valid[ptr] ? ptr : ~ptr;

	always_ff @(posedge snk_clk) begin
		if (reset) begin
			state <= IDLE;
			ptr <= 1'b0;
			link_req <= 1'b0;
			src_take <= '{default: 1'b0};
		end else begin
			src_take <= '{default: 1'b0};
			case (state)
				IDLE: begin
					if (any_valid) begin
						src_take[gnt] <= 1'b1;
						ptr <= ~gnt;
						state <= REQ;
					end
				end
				REQ: begin
					// req goes up the cycle after grant
					if (!link_req)
						link_req <= 1'b1;
					else if (link_ack) begin
						link_req <= 1'b0;
						state <= WAIT_LOW;
					end
				end
				default: begin
					if (!link_ack)
						state <= IDLE;
				end
			endcase
		end
	end

	// Held for the whole handshake
	always_ff @(posedge snk_clk) begin
		if (state == IDLE && any_valid)
			link_msg <= src_msg[gnt];
	end

endmodule

`default_nettype wire

//--- hw/msg_checker.sv
`timescale 1ns/100ps
`default_nettype none
`include "msg_settings.svh"

module msg_checker (
	input  logic snk_clk,
	input  logic reset,
	input  msg_types_pkg::msg_t link_msg,
	input  logic link_req,
	output logic link_ack,
	input  logic clear,
	output dbg_regs_pkg::err_flags_t flags,
	output logic [15:0] rx_count,
	output msg_types_pkg::msg_t last_msg
);
	import msg_types_pkg::*;
	import dbg_regs_pkg::*;

	typedef enum logic [2:0] {IDLE, CAPTURE, REDUN, CHECK, ACK} state_e;

	localparam msg_addr_t SRC0 = `MSG_SRC0_ADDR;
	localparam msg_addr_t SRC1 = `MSG_SRC1_ADDR;

	state_e state;
	msg_t cap;
	msg_red_t calc;
	msg_data_t prev_dat [2];
	logic known_src;
	logic src_sel;
	msg_data_t want_dat;
	err_flags_t hit;

	assign known_src = (cap.src == SRC0) || (cap.src == SRC1);
	assign src_sel = (cap.src == SRC1);
	assign want_dat = prev_dat[src_sel] + 1'b1;

	always_comb begin
		hit.bad_src = ~known_src;
		hit.bad_red = (calc != cap.red);
		// A previous value of 15 leaves the next one unchecked
		hit.bad_seq = known_src && (prev_dat[src_sel] != '1) && (cap.dat != want_dat);
		hit.any = hit.bad_src | hit.bad_red | hit.bad_seq;
	end

	always_ff @(posedge snk_clk) begin
		if (reset) begin
			state <= IDLE;
			link_ack <= 1'b0;
			flags <= '0;
			rx_count <= '0;
			last_msg <= '0;
			prev_dat <= '{default: '1};
		end else begin
			if (clear)
				flags <= '0;
			case (state)
				IDLE: begin
					if (link_req)
						state <= CAPTURE;
				end
				CAPTURE: state <= REDUN;
				REDUN: state <= CHECK;
				CHECK: begin
					flags <= (clear ? '0 : flags) | hit;
					rx_count <= rx_count + 1'b1;
					last_msg <= cap;
					// Resync on every message so one skip flags once
					if (known_src)
						prev_dat[src_sel] <= cap.dat;
					link_ack <= 1'b1;
					state <= ACK;
				end
				default: begin
					if (!link_req) begin
						link_ack <= 1'b0;
						state <= IDLE;
					end
				end
			endcase
		end
	end

	always_ff @(posedge snk_clk) begin
		if (state == CAPTURE)
			cap <= link_msg;
		if (state == REDUN)
			calc <= calc_redun(cap.src, cap.dst, cap.dat);
	end

endmodule

`default_nettype wire

//--- hw/msg_node_top.sv
`timescale 1ns/100ps
`default_nettype none
`include "msg_settings.svh"

module msg_node_top (
	input  logic snk_clk,
	input  logic reset,
	input  dbg_regs_pkg::apb_req_t apb_req,
	output dbg_regs_pkg::apb_rsp_t apb_rsp
);
	import msg_types_pkg::*;
	import dbg_regs_pkg::*;

	msg_t src_msg [2];
	logic src_valid [2];
	logic src_take [2];
	msg_t link_msg;
	logic link_req;
	logic link_ack;
	ctrl_t ctrl;
	logic clear;
	err_flags_t flags;
	logic [15:0] rx_count;
	msg_t last_msg;

	msg_source #(
		.SRC_ADDR(`MSG_SRC0_ADDR),
		.INJ_KIND(`MSG_INJ_RED)
	) i_src0 (
		.snk_clk(snk_clk),
		.reset(reset),
		.enable(ctrl.enable),
		.inject(ctrl.inject_red),
		.msg(src_msg[0]),
		.valid(src_valid[0]),
		.take(src_take[0])
	);

	msg_source #(
		.SRC_ADDR(`MSG_SRC1_ADDR),
		.INJ_KIND(`MSG_INJ_SEQ)
	) i_src1 (
		.snk_clk(snk_clk),
		.reset(reset),
		.enable(ctrl.enable),
		.inject(ctrl.inject_seq),
		.msg(src_msg[1]),
		.valid(src_valid[1]),
		.take(src_take[1])
	);

	link_arbiter i_arb (
		.snk_clk(snk_clk),
		.reset(reset),
		.src_msg(src_msg),
		.src_valid(src_valid),
		.src_take(src_take),
		.link_msg(link_msg),
		.link_req(link_req),
		.link_ack(link_ack)
	);

	msg_checker i_chk (
		.snk_clk(snk_clk),
		.reset(reset),
		.link_msg(link_msg),
		.link_req(link_req),
		.link_ack(link_ack),
		.clear(clear),
		.flags(flags),
		.rx_count(rx_count),
		.last_msg(last_msg)
	);

	dbg_apb_regs i_regs (
		.snk_clk(snk_clk),
		.reset(reset),
		.apb_req(apb_req),
		.apb_rsp(apb_rsp),
		.ctrl(ctrl),
		.clear(clear),
		.flags(flags),
		.rx_count(rx_count),
		.last_msg(last_msg)
	);

endmodule

`default_nettype wire

//--- hw/msg_settings.svh
`ifndef MSG_SETTINGS_SVH
`define MSG_SETTINGS_SVH

// Message field widths
`define MSG_ADDR_W 4
`define MSG_DATA_W 4
`define MSG_RED_W 4

// Destination sweep range
`define MSG_MIN_ADDR 1
`define MSG_MAX_ADDR 5

// Known source addresses
`define MSG_SRC0_ADDR 3
`define MSG_SRC1_ADDR 6

// Corruption kinds a source can inject
`define MSG_INJ_RED 0
`define MSG_INJ_SEQ 1

// APB geometry
`define APB_ADDR_W 4
`define APB_DATA_W 32

// Register byte offsets
`define REG_CTRL_OFS 0
`define REG_STATUS_OFS 4
`define REG_COUNT_OFS 8
`define REG_LAST_OFS 12

`endif

//--- hw/msg_source.sv
`timescale 1ns/100ps
`default_nettype none
`include "msg_settings.svh"

module msg_source #(
	parameter msg_types_pkg::msg_addr_t SRC_ADDR = `MSG_SRC0_ADDR,
	parameter int INJ_KIND = `MSG_INJ_RED
) (
	input  logic snk_clk,
	input  logic reset,
	input  logic enable,
	input  logic inject,
	output msg_types_pkg::msg_t msg,
	output logic valid,
	input  logic take
);
	import msg_types_pkg::*;

	typedef enum logic [1:0] {BUILD_DST, BUILD_DAT, BUILD_RED, QUEUE} state_e;

	state_e state;
	msg_addr_t dst;
	msg_data_t dat;
	msg_red_t red;
	msg_data_t cnt;
	logic inj_pend;
	logic skip_seq;
	logic flip_red;
	msg_t queue [2];
	logic wr_ptr;
	logic rd_ptr;
	logic [1:0] fill;
	logic push;
	logic pop;

	// Skip is held back while the previous data was 15, the checker ignores that step
	assign skip_seq = (INJ_KIND == `MSG_INJ_SEQ) && inj_pend && (state == BUILD_DAT) &&
		(cnt != '0);
	assign flip_red = (INJ_KIND == `MSG_INJ_RED) && inj_pend && (state == BUILD_RED);

	assign push = (state == QUEUE) && (fill != 2'd2);
	assign pop = take && valid;
	assign valid = (fill != 2'd0);
	assign msg = queue[rd_ptr];

	always_ff @(posedge snk_clk) begin
		if (reset) begin
			state <= BUILD_DST;
			dst <= msg_addr_t'(`MSG_MAX_ADDR);
			cnt <= '0;
			inj_pend <= 1'b0;
			wr_ptr <= 1'b0;
			rd_ptr <= 1'b0;
			fill <= 2'd0;
		end else begin
			inj_pend <= inject | (inj_pend & ~(skip_seq | flip_red));
			case (state)
				BUILD_DST: begin
					if (enable) begin
						dst <= (dst >= msg_addr_t'(`MSG_MAX_ADDR)) ?
							msg_addr_t'(`MSG_MIN_ADDR) : dst + 1'b1;
						state <= BUILD_DAT;
					end
				end
				BUILD_DAT: begin
					cnt <= skip_seq ? cnt + 2'd2 : cnt + 1'b1;
					state <= BUILD_RED;
				end
				BUILD_RED: state <= QUEUE;
				default: begin
					// Stall here while both slots are taken
					if (push)
						state <= BUILD_DST;
				end
			endcase
			if (push)
				wr_ptr <= ~wr_ptr;
			if (pop)
				rd_ptr <= ~rd_ptr;
			case ({push, pop})
				2'b10: fill <= fill + 1'b1;
				2'b01: fill <= fill - 1'b1;
				default: fill <= fill;
			endcase
		end
	end

	always_ff @(posedge snk_clk) begin
		if (state == BUILD_DAT)
			dat <= skip_seq ? cnt + 1'b1 : cnt;
		if (state == BUILD_RED)
			red <= calc_redun(SRC_ADDR, dst, dat) ^ msg_red_t'(flip_red);
		if (push)
			queue[wr_ptr] <= '{src: SRC_ADDR, dst: dst, dat: dat, red: red};
	end

endmodule

`default_nettype wire

//--- hw/msg_types_pkg.sv
`default_nettype none
`include "msg_settings.svh"

package msg_types_pkg;

	typedef logic [`MSG_ADDR_W-1:0] msg_addr_t;
	typedef logic [`MSG_DATA_W-1:0] msg_data_t;
	typedef logic [`MSG_RED_W-1:0] msg_red_t;

	// src in the top nibble, red in the bottom one
	typedef struct packed {
		msg_addr_t src;
		msg_addr_t dst;
		msg_data_t dat;
		msg_red_t red;
	} msg_t;

	// XOR fold of the three nibbles
	function automatic msg_red_t calc_redun(
		input msg_addr_t src,
		input msg_addr_t dst,
		input msg_data_t dat
	);
		msg_red_t code;
		code = src ^ dst ^ dat;
		return code;
	endfunction

endpackage

`default_nettype wire

//--- src.f
+incdir+hw
hw/msg_types_pkg.sv
hw/dbg_regs_pkg.sv
hw/msg_source.sv
hw/link_arbiter.sv
hw/msg_checker.sv
hw/dbg_apb_regs.sv
hw/msg_node_top.sv
testbench/tb_clock_gen.sv
testbench/msg_node_assertions.sv
testbench/msg_node_tb.sv

//--- testbench/msg_node_assertions.sv
`timescale 1ns/100ps
`default_nettype none

module msg_node_assertions (
	input  logic snk_clk,
	input  logic reset,
	input  msg_types_pkg::msg_t link_msg,
	input  logic link_req,
	input  logic link_ack,
	input  dbg_regs_pkg::ctrl_t ctrl,
	input  dbg_regs_pkg::err_flags_t flags
);
	import msg_types_pkg::*;
	import dbg_regs_pkg::*;

	int error_count = 0;
	logic inj_seen;

	// Any inject pulse so far
	always_ff @(posedge snk_clk) begin
		if (reset)
			inj_seen <= 1'b0;
		else if (ctrl.inject_red || ctrl.inject_seq)
			inj_seen <= 1'b1;
	end

	req_held: assert property (@(posedge snk_clk) disable iff (reset)
		link_req && !link_ack |=> link_req)
	else begin
		$error("link_req fell before link_ack");
		error_count++;
	end

	ack_needs_req: assert property (@(posedge snk_clk) disable iff (reset)
		$rose(link_ack) |-> link_req)
	else begin
		$error("link_ack rose without link_req");
		error_count++;
	end

	// Checker samples req, then capture, redundancy, check
	ack_latency: assert property (@(posedge snk_clk) disable iff (reset)
		$rose(link_req) |-> (!link_ack) [*4] ##1 link_ack)
	else begin
		$error("link_ack not 3 cycles after the checker saw link_req");
		error_count++;
	end

	msg_stable: assert property (@(posedge snk_clk) disable iff (reset)
		link_req && $past(link_req) |-> $stable(link_msg))
	else begin
		$error("link_msg changed while link_req was high");
		error_count++;
	end

	no_spurious_flags: assert property (@(posedge snk_clk) disable iff (reset)
		!inj_seen |-> (flags == '0))
	else begin
		$error("error flag set before any inject");
		error_count++;
	end

endmodule

bind msg_node_top msg_node_assertions i_asrt (
	.snk_clk(snk_clk),
	.reset(reset),
	.link_msg(link_msg),
	.link_req(link_req),
	.link_ack(link_ack),
	.ctrl(ctrl),
	.flags(flags)
);

`default_nettype wire

//--- testbench/msg_node_tb.sv
`timescale 1ns/100ps
`default_nettype none
`include "msg_settings.svh"

module msg_node_tb;
	import msg_types_pkg::*;
	import dbg_regs_pkg::*;

	// Test length plus margin
	localparam int WATCHDOG_CYCLES = 20000;
	localparam int MAX_POLLS = 200;

	logic snk_clk;
	logic reset;
	apb_req_t apb_req;
	apb_rsp_t apb_rsp;
	int value_errors = 0;
	int other_errors = 0;

	tb_clock_gen i_clk (
		.snk_clk(snk_clk),
		.reset(reset)
	);

	msg_node_top i_dut (
		.snk_clk(snk_clk),
		.reset(reset),
		.apb_req(apb_req),
		.apb_rsp(apb_rsp)
	);

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected)
		else begin
			$display("ERROR %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
			value_errors++;
		end
	endtask

	task automatic check_cond(input string name, input logic cond, input string what);
		assert (cond === 1'b1)
		else begin
			$display("Check %s failed: %s", name, what);
			other_errors++;
		end
	endtask

	// Setup, access, sample mid-cycle
	task automatic apb_xfer(input logic wr, input logic [`APB_ADDR_W-1:0] addr,
		input logic [31:0] wdata, output logic [31:0] rdata, output logic slverr);
		@(posedge snk_clk);
		apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
		@(posedge snk_clk);
		apb_req.penable <= 1'b1;
		@(negedge snk_clk);
		rdata = apb_rsp.prdata;
		slverr = apb_rsp.pslverr;
		check_cond("apb_ready", apb_rsp.pready, "pready was low in the access phase");
		@(posedge snk_clk);
		apb_req <= '0;
	endtask

	task automatic reg_write(input logic [`APB_ADDR_W-1:0] addr, input logic [31:0] data);
		logic [31:0] rd;
		logic err;
		apb_xfer(1'b1, addr, data, rd, err);
		check_cond("reg_write", !err, "pslverr on a write to a mapped register");
	endtask

	task automatic reg_read(input logic [`APB_ADDR_W-1:0] addr, output logic [31:0] data);
		logic err;
		apb_xfer(1'b0, addr, '0, data, err);
		check_cond("reg_read", !err, "pslverr on a read of a mapped register");
	endtask

	task automatic reg_read_check(input string name, input logic [`APB_ADDR_W-1:0] addr,
		input logic [31:0] expected);
		logic [31:0] rd;
		reg_read(addr, rd);
		check_value(name, expected, rd);
	endtask

	task automatic idle_gap();
		repeat ($urandom_range(7, 0)) @(posedge snk_clk);
	endtask

	task automatic wait_count_above(input string name, input int unsigned floor,
		output int unsigned count);
		logic [31:0] rd;
		int polls;
		polls = 0;
		count = 0;
		while (count <= floor && polls < MAX_POLLS) begin
			idle_gap();
			reg_read(`REG_COUNT_OFS, rd);
			count = rd;
			polls++;
		end
		check_cond(name, count > floor, "receive count did not rise within the poll limit");
	endtask

	task automatic wait_status_bit(input string name, input int bit_idx);
		logic [31:0] rd;
		int polls;
		polls = 0;
		rd = '0;
		while (!rd[bit_idx] && polls < MAX_POLLS) begin
			idle_gap();
			reg_read(`REG_STATUS_OFS, rd);
			polls++;
		end
		check_cond(name, rd[bit_idx], "status flag never set within the poll limit");
	endtask

	task automatic report_counts();
		$display("Error counts: value %0d, other %0d, assertion %0d",
			value_errors, other_errors, i_dut.i_asrt.error_count);
	endtask

	function automatic int total_errors();
		return value_errors + other_errors + i_dut.i_asrt.error_count;
	endfunction

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge snk_clk);
		$display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
		report_counts();
		$display("ERRORS FOUND");
		$finish;
	end

	initial begin
		logic [31:0] rd;
		logic err;
		int unsigned cnt_a;
		int unsigned cnt_b;
		msg_t last;

		apb_req <= '0;
		void'($urandom(32'hc68));
		wait (reset === 1'b0);
		@(posedge snk_clk);

		// Quiet after reset
		reg_read_check("reset_status", `REG_STATUS_OFS, 32'h0);
		reg_read_check("reset_count", `REG_COUNT_OFS, 32'h0);
		reg_read_check("reset_ctrl", `REG_CTRL_OFS, 32'h0);
		repeat (40) begin
			@(negedge snk_clk);
			check_cond("idle_link", !i_dut.link_req, "link_req rose with traffic disabled");
		end

		// Clean traffic
		reg_write(`REG_CTRL_OFS, 32'h1);
		wait_count_above("first_count", 0, cnt_a);
		wait_count_above("count_rises", cnt_a + 8, cnt_b);
		reg_read_check("clean_status", `REG_STATUS_OFS, 32'h0);
		reg_read_check("enable_ctrl", `REG_CTRL_OFS, 32'h1);
		reg_read(`REG_LAST_OFS, rd);
		last = rd[15:0];
		check_cond("last_src", last.src == 4'd3 || last.src == 4'd6,
			"last message has an unknown source");
		check_cond("last_dst", last.dst >= 4'd1 && last.dst <= 4'd5,
			"last message destination outside 1 to 5");
		check_value("last_red", {28'h0, last.src ^ last.dst ^ last.dat}, {28'h0, last.red});

		// Redundancy fault from source 0
		reg_write(`REG_CTRL_OFS, 32'h3);
		wait_status_bit("inject_red", 1);
		reg_read_check("inject_red_flags", `REG_STATUS_OFS, 32'ha);
		reg_read_check("inject_self_clear", `REG_CTRL_OFS, 32'h1);

		// Sequence fault from source 1
		reg_write(`REG_CTRL_OFS, 32'h5);
		wait_status_bit("inject_seq", 2);
		reg_read_check("inject_seq_flags", `REG_STATUS_OFS, 32'he);

		reg_write(`REG_STATUS_OFS, 32'h8);
		reg_read_check("clear_flags", `REG_STATUS_OFS, 32'h0);
		reg_read(`REG_COUNT_OFS, rd);
		cnt_a = rd;
		wait_count_above("traffic_after_clear", cnt_a + 10, cnt_b);
		reg_read_check("flags_stay_clear", `REG_STATUS_OFS, 32'h0);

		// Unmapped offsets
		apb_xfer(1'b0, 4'h6, 32'h0, rd, err);
		check_value("unmapped_read_slverr", 32'h1, {31'h0, err});
		apb_xfer(1'b1, 4'h2, 32'h0, rd, err);
		check_value("unmapped_write_slverr", 32'h1, {31'h0, err});

		repeat (4) @(posedge snk_clk);
		report_counts();
		if (total_errors() == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire

//--- testbench/tb_clock_gen.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen #(
	parameter int PERIOD_NS = 20,
	parameter int RESET_CYCLES = 8
) (
	output logic snk_clk,
	output logic reset
);

	initial begin
		snk_clk = 1'b0;
		forever #(PERIOD_NS / 2) snk_clk = ~snk_clk;
	end

	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge snk_clk);
		reset <= 1'b0;
	end

endmodule

`default_nettype wire
